/* all.f */
design/mtp_pkg.sv
design/mtp_cmd_port.sv
design/mtp_cmd_fifo.sv
design/mtp_sequencer.sv
design/mtp_macro.sv
design/mtp_subsys.sv
dv/mtp_subsys_tb.sv

/* design/mtp_cmd_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module mtp_cmd_fifo (
  input  wire               clk24,
  input  wire               nrst,
  input  wire               push,
  input  wire mtp_pkg::mtp_cmd_t push_data,
  input  wire               pop,
  output mtp_pkg::mtp_cmd_t pop_data,
  output logic              full,
  output logic              empty
);
  import mtp_pkg::*;

  typedef logic [$clog2(mtp_fifo_depth_c)-1:0] ptr_t;
  typedef logic [$clog2(mtp_fifo_depth_c):0]   cnt_t;

  mtp_cmd_t mem [mtp_fifo_depth_c];
  ptr_t     wr_ptr;
  ptr_t     rd_ptr;
  cnt_t     count;

  function automatic ptr_t next_ptr(input ptr_t p);
    return (p == ptr_t'(mtp_fifo_depth_c - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop_data = mem[rd_ptr];
  assign full     = (count == cnt_t'(mtp_fifo_depth_c));
  assign empty    = (count == '0);

  always_ff @(posedge clk24) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk24) begin
    if (!nrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither.
      endcase
    end
  end

  // port and sequencer must honour the flags.
  a_no_overflow : assert property (
    @(posedge clk24) disable iff (!nrst) push |-> !full
  );

  a_no_underflow : assert property (
    @(posedge clk24) disable iff (!nrst) pop |-> !empty
  );

endmodule

`default_nettype wire

/* design/mtp_cmd_port.sv */
`timescale 1ns/100ps
`default_nettype none

module mtp_cmd_port (
  input  wire               clk24,
  input  wire               nrst,
  input  wire               cmd_req,
  input  wire mtp_pkg::mtp_cmd_t cmd,
  output logic              cmd_ack,
  output logic              push,
  output mtp_pkg::mtp_cmd_t push_data,
  input  wire               full
);
  import mtp_pkg::*;

  // cmd_ack doubles as the receiver state.
  // low: waiting for a request, high: waiting for cmd_req to drop.
  logic req_pending;

  assign req_pending = cmd_req && !cmd_ack;

  // one push per handshake, held off while the queue is full.
  assign push      = req_pending && !full;
  assign push_data = cmd;

  always_ff @(posedge clk24) begin
    if (!nrst) begin
      cmd_ack <= 1'b0;
    end else if (push) begin
      cmd_ack <= 1'b1;  // ack after the push.
    end else if (cmd_ack && !cmd_req) begin
      cmd_ack <= 1'b0;  // return to zero.
    end
  end

  // the host keeps the command stable until it is acknowledged.
  a_cmd_stable : assert property (
    @(posedge clk24) disable iff (!nrst)
    req_pending |=> !cmd_req || $stable(cmd)
  );

endmodule

`default_nettype wire

/* design/mtp_macro.sv */
`timescale 1ns/100ps
`default_nettype none

module mtp_macro (
  input  wire  clk24,
  input  wire  nrst,
  input  wire  ip_en,
  input  wire  cp_enable,
  input  wire  read,
  input  wire  prog,
  input  wire  erase,
  input  wire  [mtp_pkg::mtp_addr_w_c-1:0] addr,
  input  wire  [mtp_pkg::mtp_data_w_c-1:0] din,
  output logic [mtp_pkg::mtp_data_w_c-1:0] dout,
  output logic ready
);
  import mtp_pkg::*;

  typedef logic [$clog2(mtp_prog_cycles_c + 1)-1:0] busy_cnt_t;

  logic [mtp_data_w_c-1:0] mem [mtp_words_c];
  logic [mtp_words_c-1:0]  erased;
  busy_cnt_t               busy_cnt;
  logic                    read_last;
  logic                    prog_last;
  logic                    erase_last;
  logic                    fail;
  logic                    addr_bad;
  logic                    op_any;
  logic                    op_done;
  logic                    op_fall;
  logic                    write_start;
  logic                    read_start;
  logic                    do_erase;
  logic                    do_prog;
  logic [mtp_addr_w_c-1:0] pair_lo;
  logic [mtp_addr_w_c-1:0] pair_hi;

  assign addr_bad = (int'(addr) >= mtp_words_c);
  assign pair_lo  = {addr[mtp_addr_w_c-1:1], 1'b0};
  assign pair_hi  = {addr[mtp_addr_w_c-1:1], 1'b1};
  assign op_any   = read || prog || erase;

  assign write_start = cp_enable && ((erase && !erase_last) || (prog && !prog_last));
  assign read_start  = read && !read_last;
  assign op_fall     = (!read && read_last) || (!prog && prog_last) || (!erase && erase_last);

  // last cycle of the busy count commits the operation.
  assign op_done  = nrst && ip_en && (busy_cnt == busy_cnt_t'(1));
  assign do_erase = op_done && cp_enable && erase && !addr_bad;
  assign do_prog  = op_done && cp_enable && prog && !addr_bad && erased[addr];

  assign ready = ip_en && !fail && (busy_cnt == '0);

  // array contents survive reset.
  always_ff @(posedge clk24) begin
    if (do_erase) begin
      mem[pair_lo] <= mtp_erased_c;
      mem[pair_hi] <= mtp_erased_c;
    end
    if (do_prog) begin
      mem[addr] <= din;
    end
  end

  always_ff @(posedge clk24) begin
    if (!nrst) begin
      busy_cnt   <= '0;
      read_last  <= 1'b0;
      prog_last  <= 1'b0;
      erase_last <= 1'b0;
      erased     <= '0;
      fail       <= 1'b0;
      dout       <= mtp_erased_c;
    end else if (!ip_en) begin
      busy_cnt   <= '0;  // macro disabled, abort.
      read_last  <= 1'b0;
      prog_last  <= 1'b0;
      erase_last <= 1'b0;
      fail       <= 1'b0;
      dout       <= mtp_erased_c;
    end else begin
      read_last  <= read;
      prog_last  <= prog;
      erase_last <= erase;

      if (busy_cnt != '0) begin
        busy_cnt <= busy_cnt - 1'b1;
      end
      if (op_fall) begin
        busy_cnt <= '0;
      end
      if (write_start) begin
        busy_cnt <= busy_cnt_t'(mtp_prog_cycles_c);
      end
      if (read_start) begin
        busy_cnt <= busy_cnt_t'(mtp_read_cycles_c);
      end
      if ((write_start || read_start) && addr_bad) begin
        fail <= 1'b1;  // sticky until ip_en drops.
      end

      if (do_erase) begin
        erased[pair_lo] <= 1'b1;
        erased[pair_hi] <= 1'b1;
      end
      if (do_prog) begin
        erased[addr] <= 1'b0;
      end
      if (op_done && read) begin
        dout <= addr_bad ? mtp_erased_c : mem[addr];
      end
    end
  end

  a_addr_stable : assert property (
    @(posedge clk24) disable iff (!nrst)
    op_any && $past(op_any) |-> $stable(addr)
  );

endmodule

`default_nettype wire

/* design/mtp_pkg.sv */
`default_nettype none

package mtp_pkg;

  // array sizing, taken from the macro.
  localparam int mtp_words_c  = 80;
  localparam int mtp_addr_w_c = 7;
  localparam int mtp_data_w_c = 16;

  localparam logic [mtp_data_w_c-1:0] mtp_erased_c = 16'hdead;

  // busy times in clk24 cycles, scaled down for simulation.
  localparam int mtp_read_cycles_c    = 6;
  localparam int mtp_prog_cycles_c    = 48;
  localparam int mtp_timeout_cycles_c = 64;

  localparam int mtp_fifo_depth_c = 4;

  typedef enum logic [1:0] {
    MTP_OP_READ  = 2'd0,
    MTP_OP_PROG  = 2'd1,
    MTP_OP_ERASE = 2'd2
  } mtp_op_e;

  typedef enum logic {
    MTP_ST_OK      = 1'b0,
    MTP_ST_TIMEOUT = 1'b1
  } mtp_status_e;

  typedef enum logic [2:0] {
    SEQ_IDLE    = 3'd0,
    SEQ_START   = 3'd1,
    SEQ_WAIT    = 3'd2,
    SEQ_RECOVER = 3'd3,
    SEQ_RESP    = 3'd4
  } mtp_seq_state_e;

  typedef struct packed {
    mtp_op_e                 op;
    logic [mtp_addr_w_c-1:0] addr;
    logic [mtp_data_w_c-1:0] wdata;
  } mtp_cmd_t;

  typedef struct packed {
    mtp_op_e                 op;
    logic [mtp_addr_w_c-1:0] addr;
    logic [mtp_data_w_c-1:0] rdata;
    mtp_status_e             status;
  } mtp_rsp_t;

endpackage

`default_nettype wire

/* design/mtp_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module mtp_sequencer (
  input  wire               clk24,
  input  wire               nrst,
  output logic              pop,
  input  wire mtp_pkg::mtp_cmd_t pop_data,
  input  wire               empty,
  output logic              ip_en,
  output logic              cp_enable,
  output logic              read,
  output logic              prog,
  output logic              erase,
  output logic [mtp_pkg::mtp_addr_w_c-1:0] addr,
  output logic [mtp_pkg::mtp_data_w_c-1:0] din,
  input  wire  [mtp_pkg::mtp_data_w_c-1:0] dout,
  input  wire               ready,
  output mtp_pkg::mtp_rsp_t rsp,
  output logic              rsp_req,
  input  wire               rsp_ack
);
  import mtp_pkg::*;

  typedef logic [$clog2(mtp_timeout_cycles_c)-1:0] wait_cnt_t;

  mtp_seq_state_e state;
  mtp_cmd_t       cmd_q;
  wait_cnt_t      wait_cnt;
  logic           op_active;
  logic           timed_out;
  logic           op_ok;

  assign pop = (state == SEQ_IDLE) && !empty;

  // operation line stays up from start until ready or timeout.
  assign op_active = (state == SEQ_START) || (state == SEQ_WAIT);
  assign read      = op_active && (cmd_q.op == MTP_OP_READ);
  assign prog      = op_active && (cmd_q.op == MTP_OP_PROG);
  assign erase     = op_active && (cmd_q.op == MTP_OP_ERASE);
  assign cp_enable = prog || erase;  // charge pump for writes.
  assign ip_en     = (state != SEQ_RECOVER);
  assign addr      = cmd_q.addr;
  assign din       = cmd_q.wdata;

  assign op_ok     = (state == SEQ_WAIT) && ready;
  assign timed_out = !ready && (wait_cnt == wait_cnt_t'(mtp_timeout_cycles_c - 1));

  always_ff @(posedge clk24) begin
    if (!nrst) begin
      state    <= SEQ_IDLE;
      wait_cnt <= '0;
      rsp_req  <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (!empty) begin
            state <= SEQ_START;
          end
        end
        SEQ_START: begin
          // macro sees the edge now and ready is sampled from the next cycle.
          wait_cnt <= '0;
          state    <= SEQ_WAIT;
        end
        SEQ_WAIT: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (ready) begin
            rsp_req <= 1'b1;
            state   <= SEQ_RESP;
          end else if (timed_out) begin
            state <= SEQ_RECOVER;
          end
        end
        SEQ_RECOVER: begin
          rsp_req <= 1'b1;  // ip_en low for this cycle.
          state   <= SEQ_RESP;
        end
        SEQ_RESP: begin
          if (rsp_req && rsp_ack) begin
            rsp_req <= 1'b0;
          end else if (!rsp_req && !rsp_ack) begin
            state <= SEQ_IDLE;
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk24) begin
    if (pop) begin
      cmd_q <= pop_data;
    end
    if (op_ok) begin
      rsp.op     <= cmd_q.op;
      rsp.addr   <= cmd_q.addr;
      rsp.rdata  <= (cmd_q.op == MTP_OP_READ) ? dout : mtp_erased_c;
      rsp.status <= MTP_ST_OK;
    end else if (state == SEQ_RECOVER) begin
      rsp.op     <= cmd_q.op;
      rsp.addr   <= cmd_q.addr;
      rsp.rdata  <= mtp_erased_c;  // no data on a stuck macro.
      rsp.status <= MTP_ST_TIMEOUT;
    end
  end

  // a command with an unknown opcode would raise no line at all.
  a_op_onehot : assert property (
    @(posedge clk24) disable iff (!nrst) op_active |-> $onehot({read, prog, erase})
  );

endmodule

`default_nettype wire

/* design/mtp_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

module mtp_subsys (
  input  wire               clk24,
  input  wire               nrst,
  input  wire               cmd_req,
  input  wire mtp_pkg::mtp_cmd_t cmd,
  output logic              cmd_ack,
  output mtp_pkg::mtp_rsp_t rsp,
  output logic              rsp_req,
  input  wire               rsp_ack
);
  import mtp_pkg::*;

  mtp_cmd_t                push_data;
  mtp_cmd_t                pop_data;
  logic                    push;
  logic                    pop;
  logic                    full;
  logic                    empty;
  logic                    ip_en;
  logic                    cp_enable;
  logic                    read;
  logic                    prog;
  logic                    erase;
  logic [mtp_addr_w_c-1:0] addr;
  logic [mtp_data_w_c-1:0] din;
  logic [mtp_data_w_c-1:0] dout;
  logic                    ready;

  mtp_cmd_port u_port (
    .clk24     (clk24),
    .nrst      (nrst),
    .cmd_req   (cmd_req),
    .cmd       (cmd),
    .cmd_ack   (cmd_ack),
    .push      (push),
    .push_data (push_data),
    .full      (full)
  );

  mtp_cmd_fifo u_fifo (
    .clk24     (clk24),
    .nrst      (nrst),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty)
  );

  mtp_sequencer u_seq (
    .clk24     (clk24),
    .nrst      (nrst),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty),
    .ip_en     (ip_en),
    .cp_enable (cp_enable),
    .read      (read),
    .prog      (prog),
    .erase     (erase),
    .addr      (addr),
    .din       (din),
    .dout      (dout),
    .ready     (ready),
    .rsp       (rsp),
    .rsp_req   (rsp_req),
    .rsp_ack   (rsp_ack)
  );

  mtp_macro u_macro (
    .clk24     (clk24),
    .nrst      (nrst),
    .ip_en     (ip_en),
    .cp_enable (cp_enable),
    .read      (read),
    .prog      (prog),
    .erase     (erase),
    .addr      (addr),
    .din       (din),
    .dout      (dout),
    .ready     (ready)
  );

endmodule

`default_nettype wire

/* dv/mtp_subsys_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mtp_subsys_tb;
  import mtp_pkg::*;

  localparam int max_vectors_c   = 64;
  localparam int clk_period_c    = 40;
  localparam int cycles_per_vec_c = 120;

  // one line of dv/mtp_vectors.txt with fields padded to whole hex digits.
  typedef struct packed {
    logic [3:0]  op;
    logic [7:0]  addr;
    logic [15:0] wdata;
    logic [15:0] rdata;
    logic [3:0]  status;
  } vector_t;

  logic     clk24;
  logic     nrst;
  logic     cmd_req;
  mtp_cmd_t cmd;
  logic     cmd_ack;
  mtp_rsp_t rsp;
  logic     rsp_req;
  logic     rsp_ack;

  logic [47:0] vector_mem [max_vectors_c];
  int          num_vectors   = 0;
  int          cycle_limit   = 0;
  int          cycle_count   = 0;
  int          rsp_count     = 0;
  int          op_errors     = 0;
  int          addr_errors   = 0;
  int          data_errors   = 0;
  int          status_errors = 0;
  int          other_errors  = 0;
  logic [31:0] lfsr;

  mtp_subsys u_dut (
    .clk24   (clk24),
    .nrst    (nrst),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .rsp     (rsp),
    .rsp_req (rsp_req),
    .rsp_ack (rsp_ack)
  );

  initial begin
    clk24 = 1'b0;
    forever #(clk_period_c / 2) clk24 = ~clk24;
  end

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_ack_delay(output int delay);
    int b;
    delay = 0;
    for (b = 0; b < 3; b++) begin
      lfsr  = lfsr_step(lfsr);
      delay = (delay << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic show_mismatch(input int idx, input string field,
                               input logic [15:0] expected, input logic [15:0] actual);
    $display("ERROR vector %0d %s: expected %h, actual %h", idx, field, expected, actual);
  endtask

  task automatic send_commands();
    int      i;
    vector_t v;
    for (i = 0; i < num_vectors; i++) begin
      v           = vector_t'(vector_mem[i]);
      cmd.op      = mtp_op_e'(v.op[1:0]);
      cmd.addr    = v.addr[mtp_addr_w_c-1:0];
      cmd.wdata   = v.wdata;
      cmd_req     = 1'b1;
      @(negedge clk24);
      while (cmd_ack !== 1'b1) @(negedge clk24);  // stalls while the queue is full.
      cmd_req = 1'b0;
      @(negedge clk24);
      while (cmd_ack !== 1'b0) @(negedge clk24);
    end
  endtask

  task automatic check_responses();
    int      i;
    int      delay;
    vector_t v;
    for (i = 0; i < num_vectors; i++) begin
      @(negedge clk24);
      while (rsp_req !== 1'b1) @(negedge clk24);
      v = vector_t'(vector_mem[i]);
      if (rsp.op !== mtp_op_e'(v.op[1:0])) begin
        show_mismatch(i, "op", 16'(v.op), 16'(rsp.op));
        op_errors++;
      end
      if (rsp.addr !== v.addr[mtp_addr_w_c-1:0]) begin
        show_mismatch(i, "addr", 16'(v.addr), 16'(rsp.addr));
        addr_errors++;
      end
      if (rsp.rdata !== v.rdata) begin
        show_mismatch(i, "rdata", v.rdata, rsp.rdata);
        data_errors++;
      end
      if (rsp.status !== mtp_status_e'(v.status[0])) begin
        show_mismatch(i, "status", 16'(v.status), 16'(rsp.status));
        status_errors++;
      end
      next_ack_delay(delay);
      repeat (delay) @(negedge clk24);
      rsp_ack = 1'b1;
      @(negedge clk24);
      while (rsp_req !== 1'b0) @(negedge clk24);
      rsp_ack = 1'b0;
      rsp_count++;
    end
  endtask

  task automatic confirm_idle();
    repeat (8) @(negedge clk24);
    if (rsp_req !== 1'b0) begin
      $display("a response arrived after all %0d vectors were answered", num_vectors);
      other_errors++;
    end
    if (cmd_ack !== 1'b0) begin
      $display("cmd_ack is still high after the last command");
      other_errors++;
    end
  endtask

  initial begin
    int i;
    int total;
    nrst    = 1'b0;
    cmd_req = 1'b0;
    cmd     = '0;
    rsp_ack = 1'b0;
    lfsr    = 32'hc420_7119;
    for (i = 0; i < max_vectors_c; i++) begin
      vector_mem[i] = {4'hf, 44'(i)};  // op nibble f marks the end.
    end
    $readmemh("dv/mtp_vectors.txt", vector_mem);
    while (num_vectors < max_vectors_c && vector_mem[num_vectors][47:44] != 4'hf) begin
      num_vectors++;
    end
    if (num_vectors == 0) begin
      $display("no vectors could be loaded from dv/mtp_vectors.txt");
      other_errors++;
    end
    cycle_limit = num_vectors * cycles_per_vec_c + 200;

    repeat (4) @(posedge clk24);
    @(negedge clk24);
    nrst = 1'b1;

    fork
      send_commands();
      check_responses();
    join
    confirm_idle();

    total = op_errors + addr_errors + data_errors + status_errors + other_errors;
    $display("errors: op %0d, addr %0d, data %0d, status %0d, other %0d, responses %0d of %0d",
             op_errors, addr_errors, data_errors, status_errors, other_errors,
             rsp_count, num_vectors);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog.
  initial begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk24);
      cycle_count++;
    end
    $display("run stopped after %0d cycles with only %0d of %0d responses received",
             cycle_count, rsp_count, num_vectors);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/mtp_vectors.txt */
// op_addr_wdata_rdata_status in hex, op 0 read, 1 program, 2 erase
// rdata is the expected read data, status 0 ok, 1 timeout
2_10_0000_dead_0
0_10_0000_dead_0
0_11_0000_dead_0
1_10_1234_dead_0
0_10_0000_1234_0
0_11_0000_dead_0
1_10_5678_dead_0
0_10_0000_1234_0
2_11_0000_dead_0
0_10_0000_dead_0
1_10_abcd_dead_0
0_10_0000_abcd_0
0_50_0000_dead_1
0_10_0000_abcd_0
1_55_4321_dead_1
2_7f_0000_dead_1
2_4e_0000_dead_0
1_4f_beef_dead_0
0_4f_0000_beef_0
2_20_0000_dead_0
1_20_1111_dead_0
1_21_2222_dead_0
0_20_0000_1111_0
0_21_0000_2222_0
2_22_0000_dead_0
1_23_3333_dead_0
0_23_0000_3333_0
0_22_0000_dead_0
0_4e_0000_dead_0

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mtp_subsys_tb -f all.f \
  || { echo "build failed"; exit 1; }
./obj_dir/Vmtp_subsys_tb > sim.log 2>&1 || echo "tests failed" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
